/* tb.f */
kbd_pkg.sv
ps2_frame_rx.sv
scan_decoder.sv
key_event_fifo.sv
ps2_keyboard_top.sv
tb_key_checker.sv
tb_ps2_keyboard.sv

/* Bender.yml */
package:
  name: ps2_keyboard

sources:
  - kbd_pkg.sv
  - ps2_frame_rx.sv
  - scan_decoder.sv
  - key_event_fifo.sv
  - ps2_keyboard_top.sv
  - target: test
    files:
      - tb_key_checker.sv
      - tb_ps2_keyboard.sv

/* tb_ps2_keyboard.sv */
`timescale 1ns/1ps

module tb_ps2_keyboard;

    localparam int FIFO_DEPTH = 8;
    // Worst case of every test, prefixed keys taking three frames
    localparam int MAX_FRAMES = 20 + 3 * 20 + 12 + (FIFO_DEPTH + 3) + 3 * 60;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * 11 * 16 + 2000;

    logic                clk;
    logic                arst_n;
    logic                ps2_clk;
    logic                ps2_data;
    logic                next_key;
    kbd_pkg::key_event_t key;
    logic                key_ready;
    logic                overflow;
    logic                frame_error;
    logic [7:0]          release_count;
    integer              seed;
    int                  cycle_count = 0;

    ps2_keyboard_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .next_key      (next_key),
        .key           (key),
        .key_ready     (key_ready),
        .overflow      (overflow),
        .frame_error   (frame_error),
        .release_count (release_count)
    );

    tb_key_checker #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_chk (
        .clk           (clk),
        .arst_n        (arst_n),
        .next_key      (next_key),
        .key           (key),
        .key_ready     (key_ready),
        .overflow      (overflow),
        .frame_error   (frame_error),
        .release_count (release_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Run stopped, no result after %0d cycles", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    // corrupt: 0 good, 1 parity, 2 start bit, 3 stop bit
    task automatic send_frame(input logic [7:0] code, input int corrupt);
        logic [10:0] bits;
        bits = {1'b1, ~(^code), code, 1'b0};  // Stop, odd parity, data, start
        if (corrupt == 1) bits[9] = ~bits[9];
        if (corrupt == 2) bits[0] = 1'b1;
        if (corrupt == 3) bits[10] = 1'b0;
        @(posedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (8) @(posedge clk);
            ps2_clk <= 1'b0;
            if (i == 10 && corrupt == 0) begin
                u_chk.sent_code = code;  // Model sees the byte before the DUT does
                -> u_chk.code_sent;
            end
            repeat (8) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;  // Idle bus
    endtask

    // form: 0 make, 1 F0+code, 2 E0+code, 3 E0+F0+code
    task automatic send_key(input int form, input logic [7:0] code);
        if (form >= 2) send_frame(kbd_pkg::SC_EXTENDED, 0);
        if (form == 1 || form == 3) send_frame(kbd_pkg::SC_RELEASE, 0);
        send_frame(code, 0);
    endtask

    function automatic logic [7:0] random_code();
        logic [7:0] code;
        code = $random(seed);
        while (code == kbd_pkg::SC_EXTENDED || code == kbd_pkg::SC_RELEASE) begin
            code = $random(seed);
        end
        return code;
    endfunction

    function automatic logic [7:0] table_code();
        logic [7:0] code;
        code = $random(seed);
        while (kbd_pkg::scan_to_ascii(code) == 8'h00) begin
            code = $random(seed);
        end
        return code;
    endfunction

    task automatic pop_key();
        @(posedge clk);
        next_key <= 1'b1;
        @(posedge clk);
        next_key <= 1'b0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!key_ready && n < 32) begin
            @(negedge clk);
            n++;
        end
        if (!key_ready) u_chk.report_problem("key_ready stuck low");
    endtask

    task automatic finish_test(input int exp_bad);
        repeat (FIFO_DEPTH + 2) begin
            @(negedge clk);
            if (key_ready) pop_key();
        end
        @(negedge clk);
        u_chk.end_test(exp_bad);
    endtask

    task automatic test_make_codes();
        u_chk.start_test("make_codes");
        repeat (20) begin
            send_key(0, table_code());
            wait_ready();
            pop_key();
        end
        finish_test(0);
    endtask

    task automatic test_prefixes();
        u_chk.start_test("prefixes");
        repeat (20) begin
            send_key({$random(seed)} % 4, random_code());
            wait_ready();
            pop_key();
        end
        finish_test(0);
    endtask

    task automatic test_bad_frames();
        int corrupt;
        int bad;
        bad = 0;
        u_chk.start_test("bad_frames");
        repeat (12) begin
            corrupt = {$random(seed)} % 4;
            send_frame(random_code(), corrupt);
            if (corrupt != 0) begin
                bad++;
            end else begin
                wait_ready();
                pop_key();
            end
        end
        finish_test(bad);
    endtask

    task automatic test_overflow();
        u_chk.start_test("overflow");
        repeat (u_dut.FIFO_DEPTH + 3) send_key(0, random_code());
        @(negedge clk);
        u_chk.check_value("overflow after burst", 1, overflow);
        finish_test(0);
    endtask

    task automatic test_random_reads();
        int pops;
        u_chk.start_test("random_reads");
        repeat (60) begin
            send_key({$random(seed)} % 4, random_code());
            pops = {$random(seed)} % 3;
            if (u_chk.model_q.size() >= FIFO_DEPTH - 2) pops = 2;  // Keep below full
            repeat (pops) begin
                repeat ({$random(seed)} % 16) @(posedge clk);
                pop_key();  // May strobe an empty queue
            end
        end
        finish_test(0);
    endtask

    initial begin
        seed     = 32'h4f0f;
        arst_n   = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        next_key = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);
        test_make_codes();
        test_prefixes();
        test_bad_frames();
        test_overflow();
        test_random_reads();
        u_chk.final_report();
        if (u_chk.tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tb_key_checker.sv */
`timescale 1ns/1ps

module tb_key_checker #(
    parameter int FIFO_DEPTH = 8
) (
    input logic                clk,
    input logic                arst_n,
    input logic                next_key,
    input kbd_pkg::key_event_t key,
    input logic                key_ready,
    input logic                overflow,
    input logic                frame_error,
    input logic [7:0]          release_count
);

    kbd_pkg::key_event_t model_q[$];  // Expected queue contents
    kbd_pkg::scan_code_t sent_code;   // Written by the frame driver
    event                code_sent;
    logic                model_ext = 1'b0;
    logic                model_rel = 1'b0;
    logic                model_overflow = 1'b0;
    logic [7:0]          model_release = 8'd0;
    int                  err_pulses = 0;
    int                  test_errors = 0;
    int                  tests_passed = 0;
    int                  tests_failed = 0;
    string               test_name = "reset";

    task automatic report_problem(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %0h, got %0h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // Decoder and queue rules applied to every good frame
    task automatic add_code(input kbd_pkg::scan_code_t code);
        kbd_pkg::key_event_t ev;
        if (code == kbd_pkg::SC_EXTENDED) begin
            model_ext = 1'b1;
        end else if (code == kbd_pkg::SC_RELEASE) begin
            model_rel = 1'b1;
        end else begin
            ev.released = model_rel;
            ev.extended = model_ext;
            ev.code     = code;
            ev.ascii    = kbd_pkg::scan_to_ascii(code);
            if (model_rel) begin
                model_release = model_release + 8'd1;  // Wraps like the DUT counter
            end
            if (model_q.size() < FIFO_DEPTH) begin
                model_q.push_back(ev);
            end else begin
                model_overflow = 1'b1;  // New event is dropped
            end
            model_ext = 1'b0;
            model_rel = 1'b0;
        end
    endtask

    always begin
        @(code_sent);
        add_code(sent_code);
    end

    always @(posedge clk) begin
        if (arst_n && frame_error) begin
            err_pulses++;
        end
        if (arst_n && next_key && key_ready) begin  // Accepted pop
            if (model_q.size() == 0) begin
                report_problem("key event that the model did not expect");
            end else begin
                check_value("key", model_q.pop_front(), key);
            end
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        err_pulses  = 0;
    endtask

    task automatic end_test(input int exp_bad);
        if (err_pulses < exp_bad) begin
            report_problem("frame_error missing");
        end else begin
            check_value("frame_error pulses", exp_bad, err_pulses);
        end
        if (model_q.size() != 0) begin
            report_problem($sformatf("key_ready stuck low, %0d events never arrived",
                                     model_q.size()));
        end
        if (key_ready) begin
            report_problem("key_ready still high after the queue was drained");
        end
        check_value("release_count", model_release, release_count);
        check_value("overflow", model_overflow, overflow);
        if (test_errors == 0) begin
            $display("PASSED %s", test_name);
            tests_passed++;
        end else begin
            $display("test %s finished with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic final_report();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    endtask

endmodule

/* ps2_keyboard_top.sv */
`timescale 1ns/1ps

module ps2_keyboard_top #(
    parameter int FIFO_DEPTH = 8  // Power of two, at least 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                next_key,
    output kbd_pkg::key_event_t key,
    output logic                key_ready,
    output logic                overflow,
    output logic                frame_error,
    output logic [7:0]          release_count
);

    logic                scan_valid;
    kbd_pkg::scan_code_t scan_code;
    logic                event_valid;
    kbd_pkg::key_event_t event_data;

    ps2_frame_rx u_rx (
        .clk         (clk),
        .arst_n      (arst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .scan_valid  (scan_valid),
        .frame_error (frame_error),
        .scan_code   (scan_code)
    );

    scan_decoder u_dec (
        .clk           (clk),
        .arst_n        (arst_n),
        .scan_valid    (scan_valid),
        .scan_code     (scan_code),
        .event_valid   (event_valid),
        .event_data    (event_data),
        .release_count (release_count)
    );

    // No back-pressure toward the decoder
    key_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (event_valid),
        .push_data (event_data),
        .next_key  (next_key),
        .key       (key),
        .key_ready (key_ready),
        .overflow  (overflow)
    );

endmodule

/* key_event_fifo.sv */
`timescale 1ns/1ps

module key_event_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                push,
    input  kbd_pkg::key_event_t push_data,
    input  logic                next_key,
    output kbd_pkg::key_event_t key,
    output logic                key_ready,
    output logic                overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    kbd_pkg::key_event_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign key_ready = (count != '0);
    assign do_push   = push & ~full;      // Full queue drops the new event
    assign do_pop    = next_key & key_ready;  // Strobe on empty is ignored
    assign key       = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);  // Depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(FIFO_DEPTH))
        else $error("key_event_fifo: occupancy above depth");

endmodule

/* scan_decoder.sv */
`timescale 1ns/1ps

module scan_decoder (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                scan_valid,
    input  kbd_pkg::scan_code_t scan_code,
    output logic                event_valid,
    output kbd_pkg::key_event_t event_data,
    output logic [7:0]          release_count
);

    logic ext_flag;  // E0 seen since last event
    logic rel_flag;  // F0 seen since last event
    logic is_ext;
    logic is_rel;
    logic is_key;

    assign is_ext = (scan_code == kbd_pkg::SC_EXTENDED);
    assign is_rel = (scan_code == kbd_pkg::SC_RELEASE);
    assign is_key = scan_valid & ~is_ext & ~is_rel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_flag      <= 1'b0;
            rel_flag      <= 1'b0;
            event_valid   <= 1'b0;
            release_count <= 8'd0;
        end else begin
            event_valid <= is_key;
            if (scan_valid && is_ext) begin
                ext_flag <= 1'b1;
            end
            if (scan_valid && is_rel) begin
                rel_flag <= 1'b1;
            end
            if (is_key) begin
                ext_flag <= 1'b0;  // Prefixes apply to one key only
                rel_flag <= 1'b0;
                if (rel_flag) begin
                    release_count <= release_count + 8'd1;  // Wraps at 255
                end
            end
        end
    end

    // Payload only, qualified by event_valid
    always_ff @(posedge clk) begin
        if (is_key) begin
            event_data.released <= rel_flag;
            event_data.extended <= ext_flag;
            event_data.code     <= scan_code;
            event_data.ascii    <= kbd_pkg::scan_to_ascii(scan_code);
        end
    end

    // Counter steps together with each released key event
    assert property (@(posedge clk) disable iff (!arst_n)
        event_valid |-> release_count == $past(release_count) + {7'd0, event_data.released})
        else $error("scan_decoder: release_count out of step with key events");

endmodule

/* ps2_frame_rx.sv */
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                scan_valid,
    output logic                frame_error,
    output kbd_pkg::scan_code_t scan_code
);

    logic [2:0] clk_sync;   // Two sync stages plus edge stage
    logic [1:0] data_sync;  // Matches clk_sync[1] latency
    logic [3:0] bit_cnt;
    logic [9:0] shift_buf;  // Start, 8 data, parity
    logic       sample;
    logic       last_bit;
    logic       frame_ok;

    assign sample   = clk_sync[2] & ~clk_sync[1];  // Falling edge of ps2_clk
    assign last_bit = (bit_cnt == 4'd10);

    // Stop bit is taken straight from the synchronizer on the 11th edge
    assign frame_ok = ~shift_buf[0] & data_sync[1] & (^shift_buf[9:1]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= 3'b111;  // Idle bus is high
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt     <= 4'd0;
            scan_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            scan_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (sample) begin
                if (last_bit) begin
                    scan_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                    bit_cnt     <= 4'd0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && !last_bit) begin
            shift_buf[bit_cnt] <= data_sync[1];  // LSB first on the wire
        end
        if (sample && last_bit) begin
            scan_code <= shift_buf[8:1];
        end
    end

    // One outcome pulse per detected edge, never two in a row
    assert property (@(posedge clk) disable iff (!arst_n)
        (scan_valid || frame_error) |=> !(scan_valid || frame_error))
        else $error("ps2_frame_rx: frame outcome pulse longer than one cycle");

endmodule

/* kbd_pkg.sv */
package kbd_pkg;

    typedef logic [7:0] scan_code_t;

    typedef struct packed {
        logic       released;  // Key went up
        logic       extended;  // E0 prefixed
        scan_code_t code;      // Set-2 make code
        logic [7:0] ascii;     // 0 when no table entry
    } key_event_t;

    localparam scan_code_t SC_EXTENDED = 8'hE0;
    localparam scan_code_t SC_RELEASE  = 8'hF0;

    // Letters and digits of scan code set 2
    function automatic logic [7:0] scan_to_ascii(input scan_code_t code);
        logic [7:0] ascii;
        case (code)
            8'h1C: ascii = 8'h41;  // A
            8'h32: ascii = 8'h42;
            8'h21: ascii = 8'h43;
            8'h23: ascii = 8'h44;
            8'h24: ascii = 8'h45;
            8'h2B: ascii = 8'h46;
            8'h34: ascii = 8'h47;
            8'h33: ascii = 8'h48;
            8'h43: ascii = 8'h49;
            8'h3B: ascii = 8'h4A;
            8'h42: ascii = 8'h4B;
            8'h4B: ascii = 8'h4C;
            8'h3A: ascii = 8'h4D;
            8'h31: ascii = 8'h4E;
            8'h44: ascii = 8'h4F;
            8'h4D: ascii = 8'h50;
            8'h15: ascii = 8'h51;
            8'h2D: ascii = 8'h52;
            8'h1B: ascii = 8'h53;
            8'h2C: ascii = 8'h54;
            8'h3C: ascii = 8'h55;
            8'h2A: ascii = 8'h56;
            8'h1D: ascii = 8'h57;
            8'h22: ascii = 8'h58;
            8'h35: ascii = 8'h59;
            8'h1A: ascii = 8'h5A;  // Z
            8'h45: ascii = 8'h30;  // 0
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39;  // 9
            default: ascii = 8'h00;
        endcase
        return ascii;
    endfunction

endpackage
